//--- hdl/axis_mux_pkg.sv
`default_nettype none

package axis_mux_pkg;

    // ########################################################################
    // field widths
    // ########################################################################

    // payload width carried by every beat.
    localparam int axis_data_w = 16;

    // source tag width.
    // three bits cover eight sources, the largest tree supported.
    localparam int axis_src_w = 3;

    // ########################################################################
    // stream beat
    // ########################################################################

    // one beat on any stream link of the tree.
    // data sits in the upper bits, the source tag in the lowest bits.
    typedef struct packed {
        // packet payload.
        logic [axis_data_w-1:0] data;
        // marks the final beat of a packet.
        logic                   last;
        // index of the leaf the beat entered through.
        logic [axis_src_w-1:0]  src;
    } axis_beat_t;

    // ########################################################################
    // arbiter state
    // ########################################################################

    // idle picks a requester, the lock states hold a grant for a packet.
    typedef enum logic [1:0] {
        // no packet in progress, free to choose.
        arb_idle   = 2'd0,
        // input a is inside a packet.
        arb_lock_a = 2'd1,
        // input b is inside a packet.
        arb_lock_b = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire

//--- hdl/axis_mux_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axis_mux_arbiter (
    input  logic aclk,
    input  logic rst,
    input  logic req_a,
    input  logic req_b,
    input  logic last_a,
    input  logic last_b,
    input  logic take,
    output logic grant_a,
    output logic grant_b
);
    import axis_mux_pkg::*;

    // current packet lock.
    arb_state_t state;
    arb_state_t state_next;
    // high when input b wins the next contested grant.
    logic       prio_b;
    // last flag of whichever input holds the grant.
    logic       last_granted;

    // ########################################################################
    // grant decision, combinational in the same cycle
    // ########################################################################

    always_comb begin
        grant_a = 1'b0;
        grant_b = 1'b0;
        case (state)
            // a locked grant stays even while its input pauses.
            arb_lock_a: grant_a = 1'b1;
            arb_lock_b: grant_b = 1'b1;
            default: begin
                if (req_a && req_b) begin
                    // both request, so the loser of the last packet goes first.
                    grant_a = !prio_b;
                    grant_b = prio_b;
                end else begin
                    grant_a = req_a;
                    grant_b = req_b;
                end
            end
        endcase
    end

    assign last_granted = grant_a ? last_a : last_b;

    // lock after a beat without last, release on the beat with last.
    always_comb begin
        state_next = state;
        if (take) begin
            if (last_granted) begin
                state_next = arb_idle;
            end else if (grant_a) begin
                state_next = arb_lock_a;
            end else begin
                state_next = arb_lock_b;
            end
        end
    end

    // ########################################################################
    // state and priority registers
    // ########################################################################

    always_ff @(posedge aclk) begin
        if (rst) begin
            state  <= arb_idle;
            // priority starts on input a.
            prio_b <= 1'b0;
        end else begin
            state <= state_next;
            // the side that just moved a beat yields the next tie.
            if (take) begin
                prio_b <= grant_a;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/axis_mux_node.sv
`timescale 1ns/100ps
`default_nettype none

module axis_mux_node (
    input  logic                     aclk,
    input  logic                     rst,
    input  axis_mux_pkg::axis_beat_t a_beat,
    input  logic                     a_valid,
    output logic                     a_ready,
    input  axis_mux_pkg::axis_beat_t b_beat,
    input  logic                     b_valid,
    output logic                     b_ready,
    output axis_mux_pkg::axis_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import axis_mux_pkg::*;

    // grants from the round-robin arbiter.
    logic       grant_a;
    logic       grant_b;
    // output slot can accept a beat this cycle.
    logic       slot_free;
    // a beat moves from an input into the slot.
    logic       take;
    // beat of the granted input.
    axis_beat_t sel_beat;

    // ########################################################################
    // input side handshake
    // ########################################################################

    // slot is free when empty or when its beat leaves this cycle.
    assign slot_free = !out_valid || out_ready;

    // only the granted input sees ready.
    assign a_ready = grant_a && slot_free;
    assign b_ready = grant_b && slot_free;

    // a locked grant may face an idle input, so valid is checked too.
    assign take = (a_valid && a_ready) || (b_valid && b_ready);

    assign sel_beat = grant_a ? a_beat : b_beat;

    // ########################################################################
    // arbitration
    // ########################################################################

    axis_mux_arbiter u_arbiter (
        .aclk    (aclk),
        .rst     (rst),
        .req_a   (a_valid),
        .req_b   (b_valid),
        .last_a  (a_beat.last),
        .last_b  (b_beat.last),
        .take    (take),
        .grant_a (grant_a),
        .grant_b (grant_b)
    );

    // ########################################################################
    // one-entry output register
    // ########################################################################

    // valid follows take whenever the slot reloads.
    always_ff @(posedge aclk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (slot_free) begin
            out_valid <= take;
        end
    end

    // payload holds while the slot waits on out_ready.
    always_ff @(posedge aclk) begin
        if (take) begin
            out_beat <= sel_beat;
        end
    end

endmodule

`default_nettype wire

//--- hdl/axis_mux_tree.sv
`timescale 1ns/100ps
`default_nettype none

module axis_mux_tree #(
    parameter int inputs = 5
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  axis_mux_pkg::axis_beat_t src_beat [inputs],
    input  logic [inputs-1:0]        src_valid,
    output logic [inputs-1:0]        src_ready,
    output axis_mux_pkg::axis_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import axis_mux_pkg::*;

    // tree depth, one level even for a single source.
    localparam int depth = (inputs >= 2) ? $clog2(inputs) : 1;
    // leaf count padded up to a power of two.
    localparam int leaves = 2**depth;
    // every link in heap order.
    // link 0 is the root output, leaves sit at the top of the range.
    localparam int links = 2 * leaves - 1;

    axis_beat_t       link_beat [links];
    logic [links-1:0] link_valid;
    logic [links-1:0] link_ready;

    // ########################################################################
    // leaves
    // ########################################################################

    for (genvar k = 0; k < leaves; k++) begin : g_leaf
        if (k < inputs) begin : g_real
            // the incoming tag is replaced by the leaf index.
            assign link_beat[leaves-1+k] = '{
                data: src_beat[k].data,
                last: src_beat[k].last,
                src:  axis_src_w'(k)
            };
            assign link_valid[leaves-1+k] = src_valid[k];
            assign src_ready[k] = link_ready[leaves-1+k];
        end else begin : g_pad
            // idle leaf, never requests.
            assign link_beat[leaves-1+k]  = '0;
            assign link_valid[leaves-1+k] = 1'b0;
        end
    end

    // ########################################################################
    // node levels
    // ########################################################################

    // level 0 is the root.
    // node idx takes links 2*idx+1 and 2*idx+2 and drives link idx.
    for (genvar lvl = 0; lvl < depth; lvl++) begin : g_level
        for (genvar n = 0; n < 2**lvl; n++) begin : g_node
            localparam int idx = 2**lvl - 1 + n;

            axis_mux_node u_node (
                .aclk      (aclk),
                .rst       (rst),
                .a_beat    (link_beat[2*idx+1]),
                .a_valid   (link_valid[2*idx+1]),
                .a_ready   (link_ready[2*idx+1]),
                .b_beat    (link_beat[2*idx+2]),
                .b_valid   (link_valid[2*idx+2]),
                .b_ready   (link_ready[2*idx+2]),
                .out_beat  (link_beat[idx]),
                .out_valid (link_valid[idx]),
                .out_ready (link_ready[idx])
            );
        end
    end

    // ########################################################################
    // root
    // ########################################################################

    // root link feeds the output stream.
    assign out_beat      = link_beat[0];
    assign out_valid     = link_valid[0];
    assign link_ready[0] = out_ready;

endmodule

`default_nettype wire

//--- hdl/axis_mux_top.sv
`timescale 1ns/100ps
`default_nettype none

module axis_mux_top #(
    // number of packet sources, 1 to 8.
    parameter int inputs = 5
) (
    input  logic                     aclk,
    input  logic                     rst,
    // source streams, one lane per source.
    input  axis_mux_pkg::axis_beat_t src_beat [inputs],
    input  logic [inputs-1:0]        src_valid,
    output logic [inputs-1:0]        src_ready,
    // shared output stream.
    output axis_mux_pkg::axis_beat_t snk_beat,
    output logic                     snk_valid,
    input  logic                     snk_ready
);

    // ########################################################################
    // arbitration tree
    // ########################################################################

    // the sink stream is the root of the tree.
    // src tags on snk_beat name the source of each beat.
    axis_mux_tree #(
        .inputs (inputs)
    ) u_axis_mux_tree (
        .aclk      (aclk),
        .rst       (rst),
        .src_beat  (src_beat),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .out_beat  (snk_beat),
        .out_valid (snk_valid),
        .out_ready (snk_ready)
    );

endmodule

`default_nettype wire

//--- test/axis_mux_src.sv
`timescale 1ns/100ps
`default_nettype none

module axis_mux_src #(
    // source number, also written into the top data bits.
    parameter int id = 0
) (
    input  logic                     aclk,
    input  logic                     rst,
    // random idle cycles between beats when high.
    input  logic                     gaps,
    // total packets this source may send so far.
    input  int                       quota,
    output axis_mux_pkg::axis_beat_t beat,
    output logic                     valid,
    input  logic                     ready
);
    import axis_mux_pkg::*;

    // beats left in the current packet including the one on the port.
    int         left;
    // packets fully handed to the DUT.
    int         sent;
    // running beat number of this source.
    logic [9:0] seq;
    // handshake seen in the middle of the cycle.
    logic       fire;
    // reset level seen in the middle of the cycle.
    logic       rst_seen;

    // data layout is id in [15:13], beats remaining in [12:10], seq in [9:0].
    initial begin
        beat     = '0;
        valid    = 1'b0;
        left     = 0;
        sent     = 0;
        seq      = '0;
        fire     = 1'b0;
        rst_seen = 1'b1;
        forever begin
            // valid, ready and rst hold from here up to the next rising edge.
            @(negedge aclk);
            fire     = valid && ready;
            rst_seen = rst;
            @(posedge aclk);
            #1;
            if (rst_seen) begin
                valid = 1'b0;
            end else begin
                if (fire) begin
                    valid = 1'b0;
                    seq   = seq + 1'b1;
                    left  = left - 1;
                    if (left == 0) begin
                        sent = sent + 1;
                    end
                end
                // new packet of 1 to 6 beats.
                if (!valid && left == 0 && sent < quota) begin
                    left = 1 + ($urandom % 6);
                end
                // about one beat in three waits a cycle when gaps are on.
                if (!valid && left > 0 && !(gaps && ($urandom % 3 == 0))) begin
                    valid     = 1'b1;
                    beat.data = {3'(id), 3'(left - 1), seq};
                    beat.last = (left == 1);
                    // deliberately wrong tag that the tree must replace.
                    beat.src  = 3'(~id);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/axis_mux_tb.sv
`timescale 1ns/100ps
`default_nettype none

module axis_mux_tb;
    import axis_mux_pkg::*;

    localparam int inputs      = 5;
    // packets per source in each phase.
    localparam int phase_pkts  = 12;
    // cycle budget for one phase.
    localparam int phase_limit = 20000;

    logic             aclk;
    logic             rst;
    wire axis_beat_t  src_beat [inputs];
    wire [inputs-1:0] src_valid;
    wire [inputs-1:0] src_ready;
    axis_beat_t       snk_beat;
    logic             snk_valid;
    logic             snk_ready;

    // stimulus mode.
    logic gaps;
    logic ready_rand;
    int   quota;

    // scoreboard state per source and for the output stream.
    logic [9:0] exp_seq  [inputs];
    int         exp_left [inputs];
    int         rcv_pkts [inputs];
    logic       in_pkt;
    logic [2:0] pkt_src;
    logic       src_moved;
    logic       stall_prev;
    axis_beat_t beat_prev;

    // ########################################################################
    // DUT, sources and sink
    // ########################################################################

    axis_mux_top #(
        .inputs (inputs)
    ) u_axis_mux_top (
        .aclk      (aclk),
        .rst       (rst),
        .src_beat  (src_beat),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .snk_beat  (snk_beat),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready)
    );

    for (genvar i = 0; i < inputs; i++) begin : g_src
        axis_mux_src #(
            .id (i)
        ) u_src (
            .aclk  (aclk),
            .rst   (rst),
            .gaps  (gaps),
            .quota (quota),
            .beat  (src_beat[i]),
            .valid (src_valid[i]),
            .ready (src_ready[i])
        );
    end

    always #4 aclk = ~aclk;

    // sink ready is random in the first phase and held high in the second.
    always begin
        @(posedge aclk);
        #1;
        snk_ready = ready_rand ? ($urandom % 3 != 0) : 1'b1;
    end

    // ########################################################################
    // failure reporting
    // ########################################################################

    task automatic fail_now();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_value_error(input string name, input int expected, input int actual);
        $display("[FAIL] time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        fail_now();
    endtask

    task automatic stop_run(input string why);
        $display("error at time %0t: %s", $time, why);
        fail_now();
    endtask

    // ########################################################################
    // scoreboard sampled mid-cycle where all signals are stable
    // ########################################################################

    always @(negedge aclk) begin : scoreboard
        int s;
        int tag;
        int remain;
        int seq;
        if (rst) begin
            for (int i = 0; i < inputs; i++) begin
                exp_seq[i]  = '0;
                exp_left[i] = -1;
                rcv_pkts[i] = 0;
            end
            in_pkt     = 1'b0;
            pkt_src    = '0;
            src_moved  = 1'b0;
            stall_prev = 1'b0;
            beat_prev  = '0;
        end else begin
            // nothing leaves the tree before something entered it.
            assert (src_moved || !snk_valid)
                else stop_run("snk_valid rose before any source transfer");
            if (|(src_valid & src_ready)) begin
                src_moved = 1'b1;
            end
            // a stalled beat must hold.
            if (stall_prev) begin
                assert (snk_valid) else report_value_error("snk_valid", 1, snk_valid);
                assert (snk_beat == beat_prev)
                    else report_value_error("snk_beat", beat_prev, snk_beat);
            end
            stall_prev = snk_valid && !snk_ready;
            beat_prev  = snk_beat;
            if (snk_valid && snk_ready) begin
                s      = snk_beat.src;
                tag    = snk_beat.data[15:13];
                remain = snk_beat.data[12:10];
                seq    = snk_beat.data[9:0];
                assert (s == tag) else report_value_error("snk_beat.src", tag, s);
                // packets from different sources never interleave.
                if (in_pkt) begin
                    assert (s == pkt_src) else report_value_error("snk_beat.src", pkt_src, s);
                end
                assert (seq == exp_seq[s])
                    else report_value_error("snk_beat.data seq", exp_seq[s], seq);
                if (exp_left[s] >= 0) begin
                    assert (remain == exp_left[s])
                        else report_value_error("snk_beat.data remain", exp_left[s], remain);
                end
                assert (snk_beat.last == (remain == 0))
                    else report_value_error("snk_beat.last", remain == 0, snk_beat.last);
                exp_seq[s]  = exp_seq[s] + 1'b1;
                exp_left[s] = (remain == 0) ? -1 : remain - 1;
                if (snk_beat.last) begin
                    rcv_pkts[s] = rcv_pkts[s] + 1;
                end
                in_pkt  = !snk_beat.last;
                pkt_src = s;
            end
        end
    end

    // ########################################################################
    // run control
    // ########################################################################

    function automatic logic all_sources_done(input int target);
        logic done;
        done = 1'b1;
        for (int i = 0; i < inputs; i++) begin
            if (rcv_pkts[i] < target) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic wait_for_packets(input int target);
        int cycles;
        cycles = 0;
        while (!all_sources_done(target)) begin
            @(posedge aclk);
            cycles++;
            if (cycles > phase_limit) begin
                stop_run("timeout, not every source finished its packets");
            end
        end
    endtask

    initial begin : main
        void'($urandom(41));
        aclk       = 1'b0;
        rst        = 1'b1;
        snk_ready  = 1'b0;
        gaps       = 1'b1;
        ready_rand = 1'b1;
        quota      = 0;
        repeat (8) @(posedge aclk);
        #1;
        rst   = 1'b0;
        quota = phase_pkts;
        // the first phase has gaps at the sources and random back-pressure.
        wait_for_packets(phase_pkts);
        // the second phase saturates all sources with the sink always ready.
        @(posedge aclk);
        gaps       = 1'b0;
        ready_rand = 1'b0;
        quota      = 2 * phase_pkts;
        wait_for_packets(2 * phase_pkts);
        // the tree drains and stays quiet.
        repeat (16) @(negedge aclk);
        assert (!snk_valid && src_valid == '0)
            else stop_run("stream still active after all packets were received");
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/axis_mux_pkg.sv
hdl/axis_mux_arbiter.sv
hdl/axis_mux_node.sv
hdl/axis_mux_tree.sv
hdl/axis_mux_top.sv
test/axis_mux_src.sv
test/axis_mux_tb.sv
